// ==== lsuPkg.sv ====
////////////////////////////////////////////////////////////
// Shared LSU types and default sizes for RTL and testbench
// Enum encodings follow the RISC-V funct3/funct7 fields
////////////////////////////////////////////////////////////
package lsuPkg;

  parameter int defaultXLen      = 32;                    // Data and address width
  parameter int defaultDtimWords = 256;                   // DTIM depth in words, power of two

  typedef enum logic [1:0] {
    memNone  = 2'b00,
    memWrite = 2'b01,
    memRead  = 2'b10,
    memAmo   = 2'b11                                      // Read then write
  } memRwT;

  typedef enum logic [2:0] {
    sizeB  = 3'b000,
    sizeH  = 3'b001,
    sizeW  = 3'b010,
    sizeBU = 3'b100,                                      // Zero-extended byte
    sizeHU = 3'b101                                       // Zero-extended halfword
  } memSizeT;

  typedef enum logic [1:0] {
    atomNone = 2'b00,
    atomLrSc = 2'b01,
    atomAmo  = 2'b10
  } atomicT;

  // funct7[6:2] of the A extension
  typedef enum logic [4:0] {
    amoAdd  = 5'b00000, amoSwap = 5'b00001, amoLr   = 5'b00010, amoSc   = 5'b00011,
    amoXor  = 5'b00100, amoOr   = 5'b01000, amoAnd  = 5'b01100, amoMin  = 5'b10000,
    amoMax  = 5'b10100, amoMinu = 5'b11000, amoMaxu = 5'b11100
  } amoOpT;

endpackage

// ==== dtimPortIf.sv ====
////////////////////////////////////////////////////////////
// DTIM port bundle, no handshake
// WriteEn is a single-cycle level sampled at the rising edge
////////////////////////////////////////////////////////////
interface dtimPortIf import lsuPkg::*; #(
  parameter int XLen      = defaultXLen,
  parameter int DtimWords = defaultDtimWords
);
  logic [$clog2(DtimWords)-1:0] WordAdr;                  // Word index into the scratchpad
  logic                         WriteEn;                  // Commit write this edge
  logic [XLen/8-1:0]            ByteMask;                 // One bit per byte lane
  logic [XLen-1:0]              WriteData;                // Lane-aligned store data
  logic [XLen-1:0]              ReadWord;                 // Raw word at WordAdr

  modport mem (input WordAdr, WriteEn, ByteMask, WriteData, output ReadWord);
  modport ctl (output WordAdr, WriteEn);
  modport fmt (output ByteMask, WriteData, input ReadWord);

endinterface

// ==== amoAlu.sv ====
////////////////////////////////////////////////////////////
// Word AMO arithmetic, RISC-V A extension rules
////////////////////////////////////////////////////////////
module amoAlu import lsuPkg::*; #(
  parameter int XLen = defaultXLen
) (
  input  logic [XLen-1:0] OldWord,                        // Memory value before the AMO
  input  logic [XLen-1:0] Operand,                        // rs2
  input  amoOpT           AmoOp,
  output logic [XLen-1:0] AmoResult
);
  logic lessSigned, lessUnsigned;

  assign lessSigned   = $signed(OldWord) < $signed(Operand);
  assign lessUnsigned = OldWord < Operand;

  always_comb begin
    case (AmoOp)
      amoSwap: AmoResult = Operand;
      amoAdd:  AmoResult = OldWord + Operand;             // Wraps, no overflow flag
      amoXor:  AmoResult = OldWord ^ Operand;
      amoOr:   AmoResult = OldWord | Operand;
      amoAnd:  AmoResult = OldWord & Operand;
      amoMin:  AmoResult = lessSigned ? OldWord : Operand;
      amoMax:  AmoResult = lessSigned ? Operand : OldWord;
      amoMinu: AmoResult = lessUnsigned ? OldWord : Operand;
      amoMaxu: AmoResult = lessUnsigned ? Operand : OldWord;
      default: AmoResult = Operand;                       // LR/SC codes never reach here
    endcase
  end

  // Control parks AmoOp on swap outside AMOs, so any other code is a bad funct7
  always_comb begin
    assert #0 (AmoOp inside {amoSwap, amoAdd, amoXor, amoOr, amoAnd,
                             amoMin, amoMax, amoMinu, amoMaxu})
      else $error("Undefined AMO op %b", AmoOp);
  end

endmodule

// ==== dtim.sv ====
////////////////////////////////////////////////////////////
// Scratchpad, combinational read, byte-masked write
// Contents are not reset
////////////////////////////////////////////////////////////
module dtim import lsuPkg::*; #(
  parameter int XLen      = defaultXLen,
  parameter int DtimWords = defaultDtimWords              // Power of two
) (
  input  logic    clk,
  dtimPortIf.mem  dtimPort
);
  logic [XLen-1:0] mem [DtimWords];                       // Word storage

  always_ff @(posedge clk) begin
    if (dtimPort.WriteEn) begin
      for (int i = 0; i < XLen/8; i++) begin
        if (dtimPort.ByteMask[i])                         // Only enabled lanes change
          mem[dtimPort.WordAdr][8*i +: 8] <= dtimPort.WriteData[8*i +: 8];
      end
    end
  end

  // Same-cycle read, new data is visible after the write edge
  assign dtimPort.ReadWord = mem[dtimPort.WordAdr];

endmodule

// ==== storeFormat.sv ====
////////////////////////////////////////////////////////////
// Store data lanes and byte mask, XLen must be 32
////////////////////////////////////////////////////////////
module storeFormat import lsuPkg::*; #(
  parameter int XLen = defaultXLen
) (
  input  logic [XLen-1:0] WriteDataM,                     // Register operand
  input  logic [XLen-1:0] AmoResult,                      // New word from AMO ALU
  input  logic [1:0]      ByteOffset,
  input  memSizeT         SizeM,
  input  logic            AmoSel,
  input  logic            BigEndianM,
  dtimPortIf.fmt          dtimPort
);
  logic [XLen-1:0]   leData;                              // Little-endian lane data
  logic [XLen/8-1:0] leMask;

  always_comb begin
    case (SizeM)
      sizeB, sizeBU: begin
        leData = {(XLen/8){WriteDataM[7:0]}};             // Byte in every lane
        leMask = {{(XLen/8-1){1'b0}}, 1'b1} << ByteOffset;
      end
      sizeH, sizeHU: begin
        leData = {(XLen/16){WriteDataM[15:0]}};
        leMask = {{(XLen/8-2){1'b0}}, 2'b11} << {ByteOffset[1], 1'b0};
      end
      default: begin
        leData = WriteDataM;
        leMask = '1;
      end
    endcase
    if (AmoSel) begin                                     // AMO writes the full word
      leData = AmoResult;
      leMask = '1;
    end
  end

  // Big endian puts offset 0 in the top lane
  assign dtimPort.WriteData = BigEndianM ? {<<8{leData}} : leData;
  assign dtimPort.ByteMask  = BigEndianM ? {<<{leMask}} : leMask;

endmodule

// ==== loadFormat.sv ====
////////////////////////////////////////////////////////////
// Load lane select and extension, XLen must be 32
// Atomics arrive as word size and take the full word
////////////////////////////////////////////////////////////
module loadFormat import lsuPkg::*; #(
  parameter int XLen = defaultXLen
) (
  input  logic [1:0]      ByteOffset,
  input  memSizeT         SizeM,
  input  logic            BigEndianM,
  dtimPortIf.fmt          dtimPort,
  output logic [XLen-1:0] LoadValue
);
  logic [XLen-1:0] leWord;                                // Word in little-endian order
  logic [7:0]      byteVal;
  logic [15:0]     halfVal;

  assign leWord = BigEndianM ? {<<8{dtimPort.ReadWord}} : dtimPort.ReadWord;

  //////////////////////////////////////////////////////////
  // Lane select
  //////////////////////////////////////////////////////////
  assign byteVal = leWord[8*ByteOffset +: 8];
  assign halfVal = leWord[16*ByteOffset[1] +: 16];        // Offset bit 0 is zero when aligned

  always_comb begin
    case (SizeM)
      sizeB:   LoadValue = {{(XLen-8){byteVal[7]}}, byteVal};
      sizeBU:  LoadValue = {{(XLen-8){1'b0}}, byteVal};
      sizeH:   LoadValue = {{(XLen-16){halfVal[15]}}, halfVal};
      sizeHU:  LoadValue = {{(XLen-16){1'b0}}, halfVal};
      default: LoadValue = leWord;                        // Word, LR and AMO
    endcase
  end

endmodule

// ==== lsuControl.sv ====
////////////////////////////////////////////////////////////
// Address register, AMO sequencer, LR/SC and fault checks
// Single reservation that every SC clears
////////////////////////////////////////////////////////////
module lsuControl import lsuPkg::*; #(
  parameter int XLen      = defaultXLen,
  parameter int DtimWords = defaultDtimWords
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            StallM,
  input  logic [XLen-1:0] IEUAdrE,
  input  memRwT           MemRWM,
  input  memSizeT         Funct3M,
  input  logic [6:0]      Funct7M,
  input  atomicT          AtomicM,
  output logic [XLen-1:0] IEUAdrM,
  output logic [1:0]      ByteOffset,
  output memSizeT         SizeM,
  output logic            AmoSel,
  output amoOpT           AmoOp,
  output logic            LSUStallM,
  output logic            SquashSCW,
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM,
  dtimPortIf.ctl          dtimPort
);
  localparam int AdrBits = $clog2(DtimWords);

  typedef enum logic {amoRead, amoWrite} amoStateT;       // amoRead also serves as idle

  amoStateT        amoState;
  logic            isLr, isSc, isAmo, isStore;
  logic            misaligned, fault;
  logic            resValid;                              // Reservation held
  logic [XLen-3:0] resAdr;                                // Reserved word address
  logic            scHit;                                 // SC would succeed

  always_ff @(posedge clk) begin
    if (reset) IEUAdrM <= '0;
    else if (~StallM & ~LSUStallM) IEUAdrM <= IEUAdrE;    // Hold across the AMO stall
  end

  //////////////////////////////////////////////////////////
  // Operation decode and misalignment
  //////////////////////////////////////////////////////////
  assign isLr    = (AtomicM == atomLrSc) & (MemRWM == memRead);
  assign isSc    = (AtomicM == atomLrSc) & (MemRWM == memWrite);
  assign isAmo   = (AtomicM == atomAmo) & (MemRWM == memAmo);
  assign isStore = (AtomicM == atomNone) & (MemRWM == memWrite);

  assign ByteOffset = IEUAdrM[1:0];
  assign SizeM      = (AtomicM != atomNone) ? sizeW : Funct3M; // Atomics are word only
  assign AmoSel     = isAmo;
  assign AmoOp      = isAmo ? amoOpT'(Funct7M[6:2]) : amoSwap; // Defined op when idle

  assign misaligned = (((SizeM == sizeH) | (SizeM == sizeHU)) & IEUAdrM[0])
                    | ((SizeM == sizeW) & (|IEUAdrM[1:0]));
  assign LoadMisalignedFaultM     = misaligned & (MemRWM == memRead);  // Includes LR
  assign StoreAmoMisalignedFaultM = misaligned & ((MemRWM == memWrite) | (MemRWM == memAmo));
  assign fault = LoadMisalignedFaultM | StoreAmoMisalignedFaultM;

  //////////////////////////////////////////////////////////
  // AMO sequencer and LR/SC reservation
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) amoState <= amoRead;
    else if (~StallM) begin
      case (amoState)
        amoRead:  if (isAmo & ~fault) amoState <= amoWrite; // Old word read this cycle
        amoWrite: amoState <= amoRead;                   // New word written at edge
        default:  amoState <= amoRead;
      endcase
    end
  end

  assign LSUStallM = isAmo & ~fault & (amoState == amoRead);
  assign scHit     = resValid & (resAdr == IEUAdrM[XLen-1:2]);

  always_ff @(posedge clk) begin
    if (reset) resValid <= 1'b0;
    else if (~StallM & ~fault) begin
      if (isLr) resValid <= 1'b1;
      else if (isSc) resValid <= 1'b0;                   // SC consumes it on pass or fail
    end
  end

  always_ff @(posedge clk) begin
    if (~StallM & ~fault & isLr) resAdr <= IEUAdrM[XLen-1:2];
  end

  always_ff @(posedge clk) begin
    if (reset) SquashSCW <= 1'b0;
    else SquashSCW <= ~StallM & isSc & ~fault & ~scHit;  // One-cycle pulse after M
  end

  assign dtimPort.WordAdr = IEUAdrM[AdrBits+1:2];        // Wraps modulo DtimWords
  assign dtimPort.WriteEn = ~StallM & ~fault
                          & (isStore | (isSc & scHit) | (isAmo & (amoState == amoWrite)));

  // A stalled pipeline changes no M-stage state
  assert property (@(posedge clk) disable iff (reset)
                   StallM |=> $stable(IEUAdrM) && $stable(amoState) && $stable(resValid))
    else $error("LSU state changed while StallM high");

  // AMO stall is released after one free-running cycle
  assert property (@(posedge clk) disable iff (reset) (LSUStallM & ~StallM) |=> ~LSUStallM)
    else $error("LSUStallM held past one unstalled cycle");

endmodule

// ==== lsu.sv ====
////////////////////////////////////////////////////////////
// Load/store unit with DTIM only, no cache, bus or MMU
// Pipeline must hold M-stage inputs while LSUStallM is high
////////////////////////////////////////////////////////////
module lsu import lsuPkg::*; #(
  parameter int XLen      = defaultXLen,                  // Byte lanes assume 32
  parameter int DtimWords = defaultDtimWords
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            StallM,                         // Freeze M stage
  input  logic [XLen-1:0] IEUAdrE,                        // Execute stage address
  input  memRwT           MemRWM,
  input  memSizeT         Funct3M,
  input  logic [6:0]      Funct7M,                        // AMO function
  input  atomicT          AtomicM,
  input  logic [XLen-1:0] WriteDataM,                     // Store or AMO operand
  input  logic            BigEndianM,
  output logic [XLen-1:0] IEUAdrM,
  output logic [XLen-1:0] ReadDataW,                      // Extended load result
  output logic            LSUStallM,                      // First AMO cycle
  output logic            SquashSCW,                      // SC failed, no GPR write
  output logic            LoadMisalignedFaultM,
  output logic            StoreAmoMisalignedFaultM
);
  logic [1:0]      ByteOffset;                            // Address bits 1:0
  memSizeT         SizeM;                                 // Forced to word for atomics
  logic            AmoSel;
  amoOpT           AmoOp;
  logic [XLen-1:0] AmoResult;                             // New word for an AMO
  logic [XLen-1:0] LoadValue;                             // Formatted read data

  dtimPortIf #(.XLen(XLen), .DtimWords(DtimWords)) dtimPort ();

  lsuControl #(.XLen(XLen), .DtimWords(DtimWords)) control (
    .clk, .reset, .StallM, .IEUAdrE, .MemRWM, .Funct3M, .Funct7M, .AtomicM,
    .IEUAdrM, .ByteOffset, .SizeM, .AmoSel, .AmoOp, .LSUStallM, .SquashSCW,
    .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM, .dtimPort(dtimPort.ctl));

  storeFormat #(.XLen(XLen)) storeFmt (
    .WriteDataM, .AmoResult, .ByteOffset, .SizeM, .AmoSel, .BigEndianM,
    .dtimPort(dtimPort.fmt));

  loadFormat #(.XLen(XLen)) loadFmt (
    .ByteOffset, .SizeM, .BigEndianM, .dtimPort(dtimPort.fmt), .LoadValue);

  // Old word taken after the endian swap so the ALU sees the logical value
  amoAlu #(.XLen(XLen)) alu (.OldWord(LoadValue), .Operand(WriteDataM), .AmoOp, .AmoResult);

  dtim #(.XLen(XLen), .DtimWords(DtimWords)) dtimMem (.clk, .dtimPort(dtimPort.mem));

  //////////////////////////////////////////////////////////
  // M to W read data register
  //////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) ReadDataW <= '0;
    else if (~StallM & ~LSUStallM) ReadDataW <= LoadValue; // AMO delivers old word here
  end

endmodule

// ==== lsuChecker.sv ====
////////////////////////////////////////////////////////////
// Reference model of the LSU, sampled at rising edges
// Assumes XLen 32 and 256 DTIM words
////////////////////////////////////////////////////////////
module lsuChecker import lsuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        StallM,
  input  logic [31:0] IEUAdrE,
  input  memRwT       MemRWM,
  input  memSizeT     Funct3M,
  input  logic [6:0]  Funct7M,
  input  atomicT      AtomicM,
  input  logic [31:0] WriteDataM,
  input  logic        BigEndianM,
  input  logic [31:0] IEUAdrM,
  input  logic [31:0] ReadDataW,
  input  logic        LSUStallM,
  input  logic        SquashSCW,
  input  logic        LoadMisalignedFaultM,
  input  logic        StoreAmoMisalignedFaultM,
  input  int          testId,                             // -1 closes the run
  input  logic        timedOut,
  output int          errCount
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] mem [256];                                 // Physical DTIM image
  logic [31:0] expAdr, expRdW;
  logic        rdValid, expSq, resV, amoPhase, toSeen;
  logic [29:0] resA;                                      // Reserved word address
  int          checks, testChecks, testErrs, curTest;
  string       testNames [7] = '{"preload", "subword", "big endian", "misalign",
                                 "lr/sc", "amo", "stall"};

  function automatic int byteCount(memSizeT s);
    case (s)
      sizeB, sizeBU: return 1;
      sizeH, sizeHU: return 2;
      default:       return 4;
    endcase
  endfunction

  // Big endian puts logical byte k of offset o in lane 3-(o+k)
  function automatic logic [31:0] readLog(logic [31:0] a, int n, logic be);
    logic [31:0] w;
    logic [31:0] v;
    int          lane;
    w = mem[a[9:2]];
    v = '0;
    for (int k = 0; k < n; k++) begin
      lane = be ? 3 - (int'(a[1:0]) + k) : int'(a[1:0]) + k;
      v[8*k +: 8] = w[8*lane +: 8];
    end
    return v;
  endfunction

  task automatic writeLog(logic [31:0] a, int n, logic be, logic [31:0] d);
    int lane;
    for (int k = 0; k < n; k++) begin
      lane = be ? 3 - (int'(a[1:0]) + k) : int'(a[1:0]) + k;
      mem[a[9:2]][8*lane +: 8] = d[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] extend(logic [31:0] v, memSizeT s);
    case (s)
      sizeB:   return {{24{v[7]}}, v[7:0]};
      sizeH:   return {{16{v[15]}}, v[15:0]};
      default: return v;                                  // Unsigned forms are already zero
    endcase
  endfunction

  function automatic logic [31:0] amoModel(logic [4:0] op, logic [31:0] old, logic [31:0] x);
    case (op)
      5'b00000: return old + x;                           // add
      5'b00100: return old ^ x;
      5'b01000: return old | x;
      5'b01100: return old & x;
      5'b10000: return ($signed(old) < $signed(x)) ? old : x;
      5'b10100: return ($signed(old) < $signed(x)) ? x : old;
      5'b11000: return (old < x) ? old : x;
      5'b11100: return (old < x) ? x : old;
      default:  return x;                                 // swap
    endcase
  endfunction

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    testChecks++;
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      errCount++;
      testErrs++;
    end
  endtask

  //////////////////////////////////////////////////////////
  // Per-edge check and model step
  //////////////////////////////////////////////////////////
  always @(posedge clk) begin : step
    int          n;
    logic        mis, isLr, isSc, isAmo, expStall, hit;
    logic [31:0] a, old;
    if (reset) begin
      expAdr = '0;
      rdValid = 0;
      expSq = 0;
      resV = 0;
      amoPhase = 0;
      toSeen = 0;
      errCount = 0;
      checks = 0;
      testChecks = 0;
      testErrs = 0;
      curTest = 0;
    end else begin
      a     = expAdr;
      n     = (AtomicM != atomNone) ? 4 : byteCount(Funct3M);
      mis   = ((n == 2) & a[0]) | ((n == 4) & (|a[1:0]));
      isLr  = (AtomicM == atomLrSc) & (MemRWM == memRead);
      isSc  = (AtomicM == atomLrSc) & (MemRWM == memWrite);
      isAmo = (AtomicM == atomAmo) & (MemRWM == memAmo);
      expStall = isAmo & ~mis & ~amoPhase;                // Stall only in first AMO cycle
      compare("IEUAdrM", expAdr, IEUAdrM);
      compare("SquashSCW", 32'(expSq), 32'(SquashSCW));
      if (rdValid) compare("ReadDataW", expRdW, ReadDataW);
      compare("LoadMisalignedFaultM", 32'(mis & (MemRWM == memRead)), 32'(LoadMisalignedFaultM));
      compare("StoreAmoMisalignedFaultM",
              32'(mis & (MemRWM == memWrite || MemRWM == memAmo)),
              32'(StoreAmoMisalignedFaultM));
      compare("LSUStallM", 32'(expStall), 32'(LSUStallM));
      expSq = 0;
      if (~StallM) begin                                  // Committing edge
        if (mis || MemRWM == memNone) rdValid = 0;
        else if (isLr) begin
          resV = 1;
          resA = a[31:2];
          expRdW = readLog(a, 4, BigEndianM);
          rdValid = 1;
        end else if (isSc) begin
          hit = resV & (resA == a[31:2]);
          if (hit) writeLog(a, 4, BigEndianM, WriteDataM);
          else expSq = 1;                                 // Failed SC squashes next cycle
          resV = 0;
          rdValid = 0;
        end else if (isAmo) begin
          if (!amoPhase) amoPhase = 1;
          else begin
            old = readLog(a, 4, BigEndianM);
            writeLog(a, 4, BigEndianM, amoModel(Funct7M[6:2], old, WriteDataM));
            expRdW = old;
            rdValid = 1;
            amoPhase = 0;
          end
        end else if (MemRWM == memRead) begin
          expRdW = extend(readLog(a, n, BigEndianM), Funct3M);
          rdValid = 1;
        end else begin
          writeLog(a, n, BigEndianM, WriteDataM);
          rdValid = 0;
        end
        if (~expStall) expAdr = IEUAdrE;
      end
      if (timedOut && !toSeen) begin
        $display("ERROR at %0t: timed out waiting for the DUT to leave stall", $time);
        toSeen = 1;
        errCount++;
      end
      if (testId != curTest) begin                        // Close the finished test
        if (curTest >= 0)
          $display("test %0d %s: %0d checks, %0d errors", curTest, testNames[curTest],
                   testChecks, testErrs);
        if (testId == -1) $display("summary: %0d checks, %0d errors", checks, errCount);
        curTest = testId;
        testChecks = 0;
        testErrs = 0;
      end
    end
  end

endmodule

// ==== lsuTb.sv ====
////////////////////////////////////////////////////////////
// LSU testbench driving inputs on the falling edge
// Random ops in a 16-word window from a fixed seed
////////////////////////////////////////////////////////////
module lsuTb import lsuPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk, reset, StallM, BigEndianM, timedOut, aborted;
  logic [31:0] IEUAdrE, WriteDataM, IEUAdrM, ReadDataW;
  memRwT       MemRWM;
  memSizeT     Funct3M;
  logic [6:0]  Funct7M;
  atomicT      AtomicM;
  logic        LSUStallM, SquashSCW, LoadMisalignedFaultM, StoreAmoMisalignedFaultM;
  int          testId, errCount, stallOdds;
  amoOpT       amoList [9] = '{amoSwap, amoAdd, amoXor, amoOr, amoAnd,
                               amoMin, amoMax, amoMinu, amoMaxu};

  lsu #(.XLen(32), .DtimWords(256)) lsu_i (.*);

  lsuChecker modelCheck (.*);

  initial begin
    clk = 0;
    forever #2 clk = ~clk;                                // 4 ns period
  end

  function automatic int sizeBytes(memSizeT s);
    return (s == sizeW) ? 4 : (s == sizeH || s == sizeHU) ? 2 : 1;
  endfunction

  function automatic memSizeT pickSize();
    case ($urandom % 5)
      0:       return sizeB;
      1:       return sizeH;
      2:       return sizeW;
      3:       return sizeBU;
      default: return sizeHU;
    endcase
  endfunction

  function automatic logic [31:0] alignedAdr(int n);
    logic [31:0] a;
    a = 32'h40 + ($urandom % 64);                         // 16-word window
    if (n == 2) a[0] = 1'b0;
    if (n == 4) a[1:0] = 2'b00;
    return a;
  endfunction

  // Bubble cycle loads the address and the M cycle holds until commit
  task automatic doOp(memRwT rw, memSizeT sz, amoOpT op, atomicT atom, logic [31:0] adr,
                      logic be);
    int   waited;
    logic committed;
    if (aborted) return;
    @(negedge clk);
    StallM = 1'b0;
    IEUAdrE = adr;
    MemRWM = memNone;
    AtomicM = atomNone;
    @(negedge clk);
    MemRWM = rw;
    Funct3M = sz;
    Funct7M = {op, 2'b00};
    AtomicM = atom;
    WriteDataM = $urandom;
    BigEndianM = be;
    committed = 0;
    waited = 0;
    while (!committed && waited < 16) begin
      StallM = ($urandom % stallOdds) == 0;
      #1;                                                 // Settled before the rising edge
      committed = ~StallM & ~LSUStallM;
      @(posedge clk);
      waited++;
      if (!committed) @(negedge clk);
    end
    @(negedge clk);                                       // Retire the op on a falling edge
    MemRWM = memNone;
    AtomicM = atomNone;
    StallM = 1'b0;
    if (!committed) begin
      timedOut = 1;
      aborted = 1;
    end
  endtask

  task automatic runMix(logic be, int count);
    memSizeT sz;
    repeat (count) begin
      sz = pickSize();
      doOp(($urandom % 2) ? memWrite : memRead, sz, amoSwap, atomNone,
           alignedAdr(sizeBytes(sz)), be);
    end
  endtask

  initial begin
    int          r;
    logic [31:0] a;
    logic        be;
    void'($urandom(32'h014ace09));
    reset = 1;
    StallM = 0;
    IEUAdrE = '0;
    MemRWM = memNone;
    Funct3M = sizeW;
    Funct7M = '0;
    AtomicM = atomNone;
    WriteDataM = '0;
    BigEndianM = 0;
    timedOut = 0;
    aborted = 0;
    testId = 0;
    stallOdds = 8;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 0;
    for (int i = 0; i < 256; i++) doOp(memWrite, sizeW, amoSwap, atomNone, 32'(i * 4), 1'b0);
    testId = 1;
    runMix(1'b0, 150);
    testId = 2;
    runMix(1'b1, 100);
    testId = 3;
    repeat (40) begin
      a = alignedAdr(4) + 32'(1 + $urandom % 3);          // Offset 1..3
      r = $urandom % 4;
      case (r)
        0:       doOp(memWrite, sizeH, amoSwap, atomNone, a | 32'h1, 1'b0);
        1:       doOp(memWrite, sizeW, amoSwap, atomNone, a, 1'b0);
        2:       doOp(memRead, sizeW, amoSwap, atomNone, a, 1'b0);
        default: doOp(memAmo, sizeW, amoAdd, atomAmo, a, 1'b0);
      endcase
      doOp(memRead, sizeW, amoSwap, atomNone, a & ~32'h3, 1'b0);
    end
    testId = 4;
    repeat (60) begin
      r = $urandom % 3;                                   // 0 means no reservation held
      a = alignedAdr(4);
      if (r != 0) doOp(memRead, sizeW, amoLr, atomLrSc, a, 1'b0);
      doOp(memWrite, sizeW, amoSc, atomLrSc, (r == 2) ? a ^ 32'h4 : a, 1'b0);
      if ($urandom % 2) doOp(memWrite, sizeW, amoSc, atomLrSc, a, 1'b0);
      doOp(memRead, sizeW, amoSwap, atomNone, a, 1'b0);
    end
    testId = 5;
    repeat (80) begin
      a = alignedAdr(4);
      be = 1'($urandom % 2);
      doOp(memAmo, sizeW, amoList[$urandom % 9], atomAmo, a, be);
      doOp(memRead, sizeW, amoSwap, atomNone, a, be);
    end
    testId = 6;
    stallOdds = 2;                                        // Heavy stall
    runMix(1'b0, 40);
    runMix(1'b1, 40);
    @(negedge clk);
    MemRWM = memNone;
    AtomicM = atomNone;
    StallM = 0;
    testId = -1;
    @(posedge clk);
    @(negedge clk);
    if (aborted || errCount != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

// ==== lsu.f ====
lsuPkg.sv
dtimPortIf.sv
amoAlu.sv
dtim.sv
storeFormat.sv
loadFormat.sv
lsuControl.sv
lsu.sv
lsuChecker.sv
lsuTb.sv

// ==== Makefile ====
# Verilator build and run of the LSU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module lsuTb -f lsu.f -o lsuSim
	@out="$$(./obj_dir/lsuSim)"; echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
